//--- src/tlul_pkg.sv
/*
 * TL-UL bus side definitions
 * Widths, vector types, opcodes and the error blanking word
 */
package tlul_pkg;

  // Bus vector types
  typedef logic [31:0] tl_addr_t;
  typedef logic [31:0] tl_data_t;
  typedef logic [3:0]  tl_mask_t;
  typedef logic [1:0]  tl_size_t;
  typedef logic [7:0]  tl_source_t;
  typedef logic [2:0]  tl_opcode_t;

  // A channel opcodes
  localparam tl_opcode_t OpPutFullData    = 3'd0;
  localparam tl_opcode_t OpPutPartialData = 3'd1;
  localparam tl_opcode_t OpGet            = 3'd4;

  // D channel opcodes
  localparam tl_opcode_t OpAccessAck      = 3'd0;
  localparam tl_opcode_t OpAccessAckData  = 3'd1;

  // Bytes per bus word
  localparam int TlBytes = 4;

  // Returned on writes and on any errored response
  localparam tl_data_t ErrBlankData = 32'hdead_beef;

endpackage

//--- src/sram_pkg.sv
/*
 * Memory side definitions for the 64-bit SRAM
 * Word address, data and error types, plus bridge FIFO sizing
 */
package sram_pkg;

  // SRAM vector types
  typedef logic [9:0]  sram_addr_t;
  typedef logic [63:0] sram_data_t;
  typedef logic [0:0]  sram_woffset_t;
  typedef logic [1:0]  sram_rerror_t;

  // Bus words per SRAM word
  localparam int WidthMult = 2;
  // Byte address bits below the SRAM word address
  localparam int SramByteBits = 3;
  // Depth of request, lane and response FIFOs
  localparam int Outstanding = 2;

  // Record widths of the three FIFOs
  // Request: {rd, err, size, source}
  localparam int ReqFifoW  = 2 + $bits(tlul_pkg::tl_size_t) + $bits(tlul_pkg::tl_source_t);
  // Lane: {mask, woffset}
  localparam int LaneFifoW = tlul_pkg::TlBytes + $bits(sram_woffset_t);
  // Response: {data, uncorrectable}
  localparam int RspFifoW  = $bits(tlul_pkg::tl_data_t) + 1;

endpackage

//--- src/req_checker.sv
/*
 * A channel legality check
 * Flags bad opcode, size, alignment and mask combinations
 */
`timescale 1ns/1ns

module req_checker
  import tlul_pkg::*;
(
  input  tl_opcode_t a_opcode_i,
  input  tl_size_t   a_size_i,
  input  tl_mask_t   a_mask_i,
  input  tl_addr_t   a_address_i,
  output logic       error_o
);

  logic     op_err;
  logic     size_err;
  logic     align_err;
  logic     mask_err;
  logic     full_err;
  tl_mask_t lanes;

  // Only Get and the two Put flavours are supported
  assign op_err = !(a_opcode_i inside {OpGet, OpPutFullData, OpPutPartialData});

  // At most a full bus word
  assign size_err = (a_size_i > 2'd2);

  // Address must be a multiple of the transfer size
  always_comb begin
    align_err = 1'b0;
    case (a_size_i)
      2'd1:    align_err = a_address_i[0];
      2'd2:    align_err = |a_address_i[1:0];
      default: align_err = 1'b0;
    endcase
  end

  // Byte lanes covered by size and address
  always_comb begin
    lanes = '0;
    case (a_size_i)
      2'd0:    lanes = tl_mask_t'(4'b0001 << a_address_i[1:0]);
      2'd1:    lanes = tl_mask_t'(4'b0011 << {a_address_i[1], 1'b0});
      2'd2:    lanes = 4'b1111;
      default: lanes = '0;
    endcase
  end

  // Empty mask or a byte outside the active lanes
  assign mask_err = (a_mask_i == '0) || |(a_mask_i & ~lanes);

  // PutFullData must write every lane of its size
  assign full_err = (a_opcode_i == OpPutFullData) && (a_mask_i != lanes);

  assign error_o = op_err | size_err | align_err | mask_err | full_err;

endmodule

//--- src/sync_fifo.sv
/*
 * Synchronous valid/ready FIFO
 * Optional pass-through forwards the write side while empty
 */
`timescale 1ns/1ns

module sync_fifo #(
  parameter int Width = 8,
  parameter int Depth = 2,
  parameter bit Pass  = 1'b0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             wvalid_i,
  output logic             wready_o,
  input  logic [Width-1:0] wdata_i,
  output logic             rvalid_o,
  input  logic             rready_i,
  output logic [Width-1:0] rdata_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             empty;
  logic             full;
  logic             pass_thru;
  logic             push;
  logic             pop;

  assign empty     = (cnt_q == '0);
  assign full      = (cnt_q == CntW'(Depth));
  assign pass_thru = Pass && empty;

  assign wready_o = ~full;
  assign rvalid_o = ~empty | (pass_thru & wvalid_i);
  // Head entry, or the incoming word when forwarding
  assign rdata_o  = pass_thru ? wdata_i : mem_q[rptr_q];

  // A forwarded word that is taken at once is never stored
  assign push = wvalid_i & ~full & ~(pass_thru & rready_i);
  assign pop  = rready_i & ~empty;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      // Occupancy follows push and pop together
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

//--- src/sram_req_gen.sv
/*
 * Request path from A channel to SRAM
 * Handles acceptance, lane placement and FIFO pushes
 */
`timescale 1ns/1ns

module sram_req_gen
  import tlul_pkg::*;
  import sram_pkg::*;
(
  input  logic                 a_valid_i,
  input  tl_opcode_t           a_opcode_i,
  input  tl_size_t             a_size_i,
  input  tl_mask_t             a_mask_i,
  input  tl_addr_t             a_address_i,
  input  tl_data_t             a_data_i,
  input  tl_source_t           a_source_i,
  input  logic                 error_i,
  input  logic                 gnt_i,
  input  logic                 reqfifo_wready_i,
  input  logic                 lanefifo_wready_i,
  output logic                 a_ready_o,
  output logic                 req_o,
  output logic                 we_o,
  output sram_addr_t           addr_o,
  output sram_data_t           wdata_o,
  output sram_data_t           wmask_o,
  output logic                 reqfifo_wvalid_o,
  output logic [ReqFifoW-1:0]  reqfifo_wdata_o,
  output logic                 lanefifo_wvalid_o,
  output logic [LaneFifoW-1:0] lanefifo_wdata_o
);

  logic          fifo_room;
  logic          is_read;
  sram_woffset_t woffset;

  // Both bookkeeping FIFOs must take an entry
  assign fifo_room = reqfifo_wready_i & lanefifo_wready_i;
  assign is_read   = (a_opcode_i == OpGet);

  // Illegal requests are acked locally without an SRAM request
  assign a_ready_o = (gnt_i | error_i) & fifo_room;
  assign req_o     = a_valid_i & fifo_room & ~error_i;
  assign we_o      = a_valid_i & (a_opcode_i inside {OpPutFullData, OpPutPartialData});
  assign addr_o    = a_valid_i ? a_address_i[SramByteBits +: $bits(sram_addr_t)] : '0;

  // Bus word position inside the SRAM word
  assign woffset = a_address_i[SramByteBits-1 -: $bits(sram_woffset_t)];

  // Place data and byte mask into the selected half, other half masked off
  always_comb begin
    wdata_o = '0;
    wmask_o = '0;
    if (a_valid_i) begin
      for (int h = 0; h < WidthMult; h++) begin
        if (sram_woffset_t'(h) == woffset) begin
          for (int b = 0; b < TlBytes; b++) begin
            wmask_o[(h*TlBytes + b)*8 +: 8] = {8{a_mask_i[b]}};
            // Unwritten bytes carry zero
            wdata_o[(h*TlBytes + b)*8 +: 8] = (a_mask_i[b] && we_o) ? a_data_i[b*8 +: 8] : 8'h00;
          end
        end
      end
    end
  end

  // Request record on every accepted A transfer
  assign reqfifo_wvalid_o = a_valid_i & a_ready_o;
  assign reqfifo_wdata_o  = {is_read, error_i, a_size_i, a_source_i};

  // Lane record only for reads actually granted by the SRAM
  assign lanefifo_wvalid_o = req_o & gnt_i & ~we_o;
  assign lanefifo_wdata_o  = {a_mask_i, woffset};

endmodule

//--- src/rsp_gen.sv
/*
 * Response path from SRAM to D channel
 * Selects and masks read data, builds D beats, pops the FIFOs
 */
`timescale 1ns/1ns

module rsp_gen
  import tlul_pkg::*;
  import sram_pkg::*;
(
  input  logic                 reqfifo_rvalid_i,
  input  logic [ReqFifoW-1:0]  reqfifo_rdata_i,
  input  logic [LaneFifoW-1:0] lanefifo_rdata_i,
  input  logic                 rvalid_i,
  input  sram_data_t           rdata_i,
  input  sram_rerror_t         rerror_i,
  input  logic                 rspfifo_rvalid_i,
  input  logic [RspFifoW-1:0]  rspfifo_rdata_i,
  input  logic                 d_ready_i,
  output logic                 rspfifo_wvalid_o,
  output logic [RspFifoW-1:0]  rspfifo_wdata_o,
  output logic                 lanefifo_rready_o,
  output logic                 reqfifo_rready_o,
  output logic                 rspfifo_rready_o,
  output logic                 d_valid_o,
  output tl_opcode_t           d_opcode_o,
  output tl_size_t             d_size_o,
  output tl_source_t           d_source_o,
  output tl_data_t             d_data_o,
  output logic                 d_error_o
);

  logic          req_rd;
  logic          req_err;
  tl_size_t      req_size;
  tl_source_t    req_source;
  tl_mask_t      lane_mask;
  sram_woffset_t lane_woffset;
  tl_data_t      rd_word;
  tl_data_t      rd_masked;
  tl_data_t      rsp_data;
  logic          rsp_err;
  logic          d_ack;
  logic          good_read;

  // Unpack FIFO records
  assign {req_rd, req_err, req_size, req_source} = reqfifo_rdata_i;
  assign {lane_mask, lane_woffset}               = lanefifo_rdata_i;
  assign {rsp_data, rsp_err}                     = rspfifo_rdata_i;

  // Addressed half of the SRAM word
  assign rd_word = rdata_i[lane_woffset * $bits(tl_data_t) +: $bits(tl_data_t)];

  // Zero the bytes that were not requested
  always_comb begin
    rd_masked = '0;
    for (int b = 0; b < TlBytes; b++) begin
      rd_masked[b*8 +: 8] = lane_mask[b] ? rd_word[b*8 +: 8] : 8'h00;
    end
  end

  // Read return goes into the response FIFO, lane entry retires with it
  assign rspfifo_wvalid_o  = rvalid_i;
  // Only the uncorrectable bit matters
  assign rspfifo_wdata_o   = {rd_masked, rerror_i[1]};
  assign lanefifo_rready_o = rvalid_i;

  // Writes and errors answer at once, reads wait for data
  assign d_valid_o = reqfifo_rvalid_i & (req_err | ~req_rd | rspfifo_rvalid_i);
  assign d_ack     = d_valid_o & d_ready_i;

  assign reqfifo_rready_o = d_ack;
  // Errored reads never reached the SRAM, so nothing to pop
  assign rspfifo_rready_o = d_ack & req_rd & ~req_err;

  assign good_read = req_rd & ~req_err & ~rsp_err;

  assign d_opcode_o = req_rd ? OpAccessAckData : OpAccessAck;
  assign d_size_o   = d_valid_o ? req_size : '0;
  assign d_source_o = d_valid_o ? req_source : '0;
  assign d_error_o  = d_valid_o & (req_err | (req_rd & rsp_err));
  assign d_data_o   = (d_valid_o && good_read) ? rsp_data : ErrBlankData;

endmodule

//--- src/tlul_sram_adapter.sv
/*
 * TL-UL to 64-bit SRAM bridge top level
 * Checker, request and response paths around three FIFOs
 */
`timescale 1ns/1ns

module tlul_sram_adapter
  import tlul_pkg::*;
  import sram_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // A channel
  input  logic         a_valid_i,
  input  tl_opcode_t   a_opcode_i,
  input  tl_size_t     a_size_i,
  input  tl_mask_t     a_mask_i,
  input  tl_addr_t     a_address_i,
  input  tl_data_t     a_data_i,
  input  tl_source_t   a_source_i,
  output logic         a_ready_o,
  // D channel
  output logic         d_valid_o,
  output tl_opcode_t   d_opcode_o,
  output tl_size_t     d_size_o,
  output tl_source_t   d_source_o,
  output tl_data_t     d_data_o,
  output logic         d_error_o,
  input  logic         d_ready_i,
  // SRAM port
  output logic         req_o,
  output logic         we_o,
  output sram_addr_t   addr_o,
  output sram_data_t   wdata_o,
  output sram_data_t   wmask_o,
  input  logic         gnt_i,
  input  logic         rvalid_i,
  input  sram_data_t   rdata_i,
  input  sram_rerror_t rerror_i
);

  logic                 req_err;

  logic                 reqfifo_wvalid;
  logic                 reqfifo_wready;
  logic [ReqFifoW-1:0]  reqfifo_wdata;
  logic                 reqfifo_rvalid;
  logic                 reqfifo_rready;
  logic [ReqFifoW-1:0]  reqfifo_rdata;

  logic                 lanefifo_wvalid;
  logic                 lanefifo_wready;
  logic [LaneFifoW-1:0] lanefifo_wdata;
  logic                 lanefifo_rready;
  logic [LaneFifoW-1:0] lanefifo_rdata;

  logic                 rspfifo_wvalid;
  logic [RspFifoW-1:0]  rspfifo_wdata;
  logic                 rspfifo_rvalid;
  logic                 rspfifo_rready;
  logic [RspFifoW-1:0]  rspfifo_rdata;

  // Request legality
  req_checker u_req_checker (
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_mask_i    (a_mask_i),
    .a_address_i (a_address_i),
    .error_o     (req_err)
  );

  // A channel to SRAM
  sram_req_gen u_sram_req_gen (
    .a_valid_i         (a_valid_i),
    .a_opcode_i        (a_opcode_i),
    .a_size_i          (a_size_i),
    .a_mask_i          (a_mask_i),
    .a_address_i       (a_address_i),
    .a_data_i          (a_data_i),
    .a_source_i        (a_source_i),
    .error_i           (req_err),
    .gnt_i             (gnt_i),
    .reqfifo_wready_i  (reqfifo_wready),
    .lanefifo_wready_i (lanefifo_wready),
    .a_ready_o         (a_ready_o),
    .req_o             (req_o),
    .we_o              (we_o),
    .addr_o            (addr_o),
    .wdata_o           (wdata_o),
    .wmask_o           (wmask_o),
    .reqfifo_wvalid_o  (reqfifo_wvalid),
    .reqfifo_wdata_o   (reqfifo_wdata),
    .lanefifo_wvalid_o (lanefifo_wvalid),
    .lanefifo_wdata_o  (lanefifo_wdata)
  );

  // Keeps responses in request order
  sync_fifo #(
    .Width (ReqFifoW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_reqfifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (reqfifo_wvalid),
    .wready_o (reqfifo_wready),
    .wdata_i  (reqfifo_wdata),
    .rvalid_o (reqfifo_rvalid),
    .rready_i (reqfifo_rready),
    .rdata_o  (reqfifo_rdata)
  );

  // Mask and half of each read until its data returns
  sync_fifo #(
    .Width (LaneFifoW),
    .Depth (Outstanding),
    .Pass  (1'b0)
  ) u_lanefifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (lanefifo_wvalid),
    .wready_o (lanefifo_wready),
    .wdata_i  (lanefifo_wdata),
    .rvalid_o (),
    .rready_i (lanefifo_rready),
    .rdata_o  (lanefifo_rdata)
  );

  // SRAM cannot stall, so read data is parked here under D back-pressure
  sync_fifo #(
    .Width (RspFifoW),
    .Depth (Outstanding),
    .Pass  (1'b1)
  ) u_rspfifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rspfifo_wvalid),
    .wready_o (),
    .wdata_i  (rspfifo_wdata),
    .rvalid_o (rspfifo_rvalid),
    .rready_i (rspfifo_rready),
    .rdata_o  (rspfifo_rdata)
  );

  // SRAM to D channel
  rsp_gen u_rsp_gen (
    .reqfifo_rvalid_i  (reqfifo_rvalid),
    .reqfifo_rdata_i   (reqfifo_rdata),
    .lanefifo_rdata_i  (lanefifo_rdata),
    .rvalid_i          (rvalid_i),
    .rdata_i           (rdata_i),
    .rerror_i          (rerror_i),
    .rspfifo_rvalid_i  (rspfifo_rvalid),
    .rspfifo_rdata_i   (rspfifo_rdata),
    .d_ready_i         (d_ready_i),
    .rspfifo_wvalid_o  (rspfifo_wvalid),
    .rspfifo_wdata_o   (rspfifo_wdata),
    .lanefifo_rready_o (lanefifo_rready),
    .reqfifo_rready_o  (reqfifo_rready),
    .rspfifo_rready_o  (rspfifo_rready),
    .d_valid_o         (d_valid_o),
    .d_opcode_o        (d_opcode_o),
    .d_size_o          (d_size_o),
    .d_source_o        (d_source_o),
    .d_data_o          (d_data_o),
    .d_error_o         (d_error_o)
  );

endmodule

//--- test/tb_clk_gen.sv
/*
 * Testbench clock and reset source
 */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PeriodNs    = 20,
  parameter int ResetCycles = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release reset just after an edge, clear of the DUT sampling point
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

//--- test/tb_sram_model.sv
/*
 * Behavioral 64-bit single-port SRAM
 * Random grant, bit-masked writes, one-cycle read latency with random errors
 */
`timescale 1ns/1ns

module tb_sram_model
  import sram_pkg::*;
#(
  parameter logic [31:0] Seed = 32'h1
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         req_i,
  input  logic         we_i,
  input  sram_addr_t   addr_i,
  input  sram_data_t   wdata_i,
  input  sram_data_t   wmask_i,
  output logic         gnt_o,
  output logic         rvalid_o,
  output sram_data_t   rdata_o,
  output sram_rerror_t rerror_o
);

  localparam int Words = 2 ** $bits(sram_addr_t);

  sram_data_t  mem [Words];
  integer      seed;
  logic [31:0] r;
  logic        rd_hit;
  sram_data_t  rd_word;

  initial begin
    seed     = Seed;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    rerror_o = '0;
    // Fill pattern built from the whole word address
    for (int i = 0; i < Words; i++) begin
      mem[i] = {32'(i) * 32'h9e37_79b9, ~(32'(i) * 32'h85eb_ca6b)};
    end
  end

  // Sample on the edge, drive outputs 2 ns later
  always @(posedge clk_i) begin
    rd_hit = rst_ni && req_i && gnt_o && !we_i;
    if (rst_ni && req_i && gnt_o && we_i) begin
      mem[addr_i] = (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
    end
    rd_word = mem[addr_i];
    r = $random(seed);
    #2;
    // Grant about three cycles in four
    gnt_o    = rst_ni && (r[1:0] != 2'b00);
    rvalid_o = rd_hit;
    rdata_o  = rd_hit ? rd_word : '0;
    // Each error bit set about one read in eight
    rerror_o = rd_hit ? {r[4:2] == 3'd0, r[7:5] == 3'd0} : '0;
  end

endmodule

//--- test/tlul_sram_adapter_chk.sv
/*
 * Protocol assertions bound into the bridge top level
 */
`timescale 1ns/1ns

module tlul_adapter_chk
  import tlul_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input logic       d_valid_i,
  input logic       d_ready_i,
  input tl_opcode_t d_opcode_i,
  input tl_size_t   d_size_i,
  input tl_source_t d_source_i,
  input tl_data_t   d_data_i,
  input logic       d_error_i,
  input logic       req_i,
  input tl_opcode_t a_opcode_i,
  input tl_size_t   a_size_i,
  input tl_mask_t   a_mask_i,
  input tl_addr_t   a_address_i
);

  // Legality of an A request, from the bus rules alone
  function automatic logic legal_request(input tl_opcode_t op, input tl_size_t size,
                                         input tl_mask_t mask, input tl_addr_t addr);
    tl_mask_t lanes;
    logic     aligned;
    case (size)
      2'd0:    lanes = tl_mask_t'(4'b0001 << addr[1:0]);
      2'd1:    lanes = addr[1] ? 4'b1100 : 4'b0011;
      default: lanes = 4'b1111;
    endcase
    // Size 3 is never aligned, so it is never legal
    aligned = (size == 2'd0) || (size == 2'd1 && !addr[0]) ||
              (size == 2'd2 && addr[1:0] == 2'b00);
    return (op == OpGet || op == OpPutFullData || op == OpPutPartialData) && aligned &&
           (mask != '0) && ((mask & ~lanes) == '0) &&
           (op != OpPutFullData || mask == lanes);
  endfunction

  // A stalled D beat keeps valid and every field
  d_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_i && !d_ready_i |=> d_valid_i &&
      $stable({d_opcode_i, d_size_i, d_source_i, d_data_i, d_error_i}))
    else $error("D channel changed while stalled");

  // Illegal requests stay away from the SRAM
  no_bad_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> legal_request(a_opcode_i, a_size_i, a_mask_i, a_address_i))
    else $error("SRAM request raised for an illegal A request");

  rst_d_idle_a : assert property (@(posedge clk_i) !rst_ni |-> !d_valid_i)
    else $error("D valid high during reset");

endmodule

bind tlul_sram_adapter tlul_adapter_chk u_chk (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .d_valid_i   (d_valid_o),
  .d_ready_i   (d_ready_i),
  .d_opcode_i  (d_opcode_o),
  .d_size_i    (d_size_o),
  .d_source_i  (d_source_o),
  .d_data_i    (d_data_o),
  .d_error_i   (d_error_o),
  .req_i       (req_o),
  .a_opcode_i  (a_opcode_i),
  .a_size_i    (a_size_i),
  .a_mask_i    (a_mask_i),
  .a_address_i (a_address_i)
);

//--- test/tb_tlul_sram_adapter.sv
/*
 * Testbench for the TL-UL to SRAM bridge
 * Seeded random legal and illegal traffic checked against a shadow memory
 */
`timescale 1ns/1ns

module tb_tlul_sram_adapter
  import tlul_pkg::*;
  import sram_pkg::*;
();

  localparam int          ClkPeriod  = 20;
  localparam int          NumTxn     = 300;
  localparam int          WatchdogNs = NumTxn * 20 * ClkPeriod;
  localparam logic [31:0] SeedInit   = 32'he887_028f;

  // One expected D beat
  typedef struct {
    tl_opcode_t op;
    tl_size_t   size;
    tl_source_t source;
    tl_data_t   data;
    logic       err;
    logic       rd;
  } exp_rsp_t;

  logic         clk_i;
  logic         rst_ni;
  logic         a_valid_i;
  tl_opcode_t   a_opcode_i;
  tl_size_t     a_size_i;
  tl_mask_t     a_mask_i;
  tl_addr_t     a_address_i;
  tl_data_t     a_data_i;
  tl_source_t   a_source_i;
  logic         a_ready_o;
  logic         d_valid_o;
  tl_opcode_t   d_opcode_o;
  tl_size_t     d_size_o;
  tl_source_t   d_source_o;
  tl_data_t     d_data_o;
  logic         d_error_o;
  logic         d_ready_i;
  logic         req_o;
  logic         we_o;
  sram_addr_t   addr_o;
  sram_data_t   wdata_o;
  sram_data_t   wmask_o;
  logic         gnt_i;
  logic         rvalid_i;
  sram_data_t   rdata_i;
  sram_rerror_t rerror_i;

  exp_rsp_t     exp_q [$];
  logic         rerr_q [$];
  // Shadow memory by bus word address
  tl_data_t     shadow [2048];
  integer       seed;
  int           fail_count;
  int           rsp_count;
  logic         drv_illegal;
  logic         held;
  logic [45:0]  held_fields;

  tb_clk_gen #(
    .PeriodNs    (ClkPeriod),
    .ResetCycles (3)
  ) u_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  tb_sram_model #(
    .Seed (SeedInit)
  ) u_sram (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_o),
    .we_i     (we_o),
    .addr_i   (addr_o),
    .wdata_i  (wdata_o),
    .wmask_i  (wmask_o),
    .gnt_o    (gnt_i),
    .rvalid_o (rvalid_i),
    .rdata_o  (rdata_i),
    .rerror_o (rerror_i)
  );

  tlul_sram_adapter tlul_sram_adapter_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_valid_i   (a_valid_i),
    .a_opcode_i  (a_opcode_i),
    .a_size_i    (a_size_i),
    .a_mask_i    (a_mask_i),
    .a_address_i (a_address_i),
    .a_data_i    (a_data_i),
    .a_source_i  (a_source_i),
    .a_ready_o   (a_ready_o),
    .d_valid_o   (d_valid_o),
    .d_opcode_o  (d_opcode_o),
    .d_size_o    (d_size_o),
    .d_source_o  (d_source_o),
    .d_data_o    (d_data_o),
    .d_error_o   (d_error_o),
    .d_ready_i   (d_ready_i),
    .req_o       (req_o),
    .we_o        (we_o),
    .addr_o      (addr_o),
    .wdata_o     (wdata_o),
    .wmask_o     (wmask_o),
    .gnt_i       (gnt_i),
    .rvalid_i    (rvalid_i),
    .rdata_i     (rdata_i),
    .rerror_i    (rerror_i)
  );

  task automatic report_mismatch(input string msg);
    fail_count++;
    $display("FAIL %0t ns: %s", $time, msg);
    $display("TEST FAIL");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  task automatic report_problem(input string msg);
    fail_count++;
    $display("%s at %0t ns", msg, $time);
    $display("TEST FAIL");
    $fatal(1, "Stopped on a protocol problem");
  endtask

  task automatic check_data(input tl_data_t got, input tl_data_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s data got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_source(input tl_source_t got, input tl_source_t exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s source got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_opcode(input tl_opcode_t got, input tl_opcode_t exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s opcode got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_size(input tl_size_t got, input tl_size_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s size got %0d expected %0d", what, got, exp));
    end
  endtask

  task automatic check_error(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s error got %b expected %b", what, got, exp));
    end
  endtask

  // Byte lanes that a size and low address may touch
  function automatic tl_mask_t lanes_of(input tl_size_t size, input logic [1:0] offs);
    case (size)
      2'd0:    return tl_mask_t'(4'b0001 << offs);
      2'd1:    return offs[1] ? 4'b1100 : 4'b0011;
      default: return 4'b1111;
    endcase
  endfunction

  // Byte mask to bit mask
  function automatic tl_data_t bytes_of(input tl_mask_t mask);
    tl_data_t m;
    for (int b = 0; b < TlBytes; b++) begin
      m[b*8 +: 8] = {8{mask[b]}};
    end
    return m;
  endfunction

  // Turn the current legal request into one that breaks a single rule
  task automatic break_request();
    logic [31:0] r;
    r = $random(seed);
    drv_illegal = 1'b1;
    case (r[2:0])
      3'd0, 3'd6: a_opcode_i = r[4] ? {2'b01, r[5]} : {1'b1, (r[6:5] == 2'b00) ? 2'b10 : r[6:5]};
      3'd1, 3'd7: a_size_i = 2'd3;
      3'd2: begin
        a_size_i         = 2'd2;
        a_address_i[1:0] = (r[6:5] == 2'b00) ? 2'b01 : r[6:5];
      end
      3'd3: a_mask_i = '0;
      3'd4: begin
        // Own byte plus its neighbour
        a_size_i         = 2'd0;
        a_address_i[1:0] = r[6:5];
        a_mask_i         = lanes_of(2'd0, r[6:5]) | lanes_of(2'd0, r[6:5] + 2'd1);
      end
      default: begin
        a_opcode_i       = OpPutFullData;
        a_size_i         = 2'd2;
        a_address_i[1:0] = 2'b00;
        a_mask_i         = 4'hf & ~(4'b0001 << r[6:5]);
      end
    endcase
  endtask

  // Traffic kinds: 0 full write, 1 full read, 2 partial write, 3 partial read, 4 illegal
  task automatic make_request(input int idx);
    logic [31:0] r;
    int          kind;
    tl_mask_t    lanes;
    r = $random(seed);
    if (idx < 64) begin
      kind = 0;
    end else if (idx < 144) begin
      kind = r[0] ? 0 : 1;
    end else if (idx < 204) begin
      kind = r[0] ? 2 : 3;
    end else if (idx < 234) begin
      kind = 4;
    end else begin
      kind = r[2:0] % 5;
    end
    a_valid_i   = 1'b1;
    drv_illegal = 1'b0;
    a_source_i  = r[15:8];
    a_data_i    = $random(seed);
    // Prefill walks all 64 words, later traffic hits them at random
    a_address_i = {24'h0, (idx < 64) ? idx[5:0] : r[21:16], 2'b00};
    a_size_i    = 2'd2;
    a_mask_i    = 4'hf;
    a_opcode_i  = (kind == 1 || kind == 3) ? OpGet : OpPutFullData;
    if (kind >= 2) begin
      a_size_i = (r[23:22] == 2'd3) ? 2'd2 : r[23:22];
      if (a_size_i == 2'd0) begin
        a_address_i[1:0] = r[25:24];
      end else if (a_size_i == 2'd1) begin
        a_address_i[1:0] = {r[24], 1'b0};
      end
      lanes    = lanes_of(a_size_i, a_address_i[1:0]);
      a_mask_i = lanes & r[29:26];
      if (a_mask_i == '0) begin
        a_mask_i = lanes;
      end
      if (kind == 2) begin
        a_opcode_i = (a_mask_i == lanes && r[30]) ? OpPutFullData : OpPutPartialData;
      end else if (kind == 4) begin
        a_opcode_i = r[30] ? OpGet : OpPutPartialData;
        break_request();
      end
    end
  endtask

  // Reference model update on an accepted A transfer
  task automatic record_accept();
    exp_rsp_t    e;
    logic [10:0] idx;
    idx      = a_address_i[12:2];
    e.op     = (a_opcode_i == OpGet) ? OpAccessAckData : OpAccessAck;
    e.size   = a_size_i;
    e.source = a_source_i;
    e.data   = ErrBlankData;
    e.err    = drv_illegal;
    e.rd     = 1'b0;
    if (!drv_illegal && a_opcode_i == OpGet) begin
      e.rd   = 1'b1;
      e.data = shadow[idx] & bytes_of(a_mask_i);
    end else if (!drv_illegal) begin
      shadow[idx] = (shadow[idx] & ~bytes_of(a_mask_i)) | (a_data_i & bytes_of(a_mask_i));
    end
    exp_q.push_back(e);
  endtask

  // D channel and SRAM side monitor, sampled on the rising edge
  always @(posedge clk_i) begin : d_monitor
    exp_rsp_t e;
    string    what;
    if (!rst_ni) begin
      held = 1'b0;
      if (d_valid_o) begin
        report_problem("D valid was high during reset");
      end
    end else begin
      if (held && (!d_valid_o ||
          {d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o} !== held_fields)) begin
        report_problem("D channel changed while the host was stalling it");
      end
      held        = d_valid_o && !d_ready_i;
      held_fields = {d_opcode_o, d_size_o, d_source_o, d_data_o, d_error_o};
      if (a_valid_i && req_o && drv_illegal) begin
        report_problem("SRAM request was raised for an illegal A request");
      end
      // Uncorrectable flag of each SRAM read, in order
      if (rvalid_i) begin
        rerr_q.push_back(rerror_i[1]);
      end
      if (d_valid_o && d_ready_i) begin
        if (exp_q.size() == 0) begin
          report_problem("A response arrived with no request outstanding");
        end else if (exp_q[0].rd && rerr_q.size() == 0) begin
          report_problem("A read response arrived before its SRAM data");
        end else begin
          e = exp_q.pop_front();
          if (e.rd && rerr_q.pop_front()) begin
            e.err  = 1'b1;
            e.data = ErrBlankData;
          end
          what = $sformatf("response %0d", rsp_count);
          check_opcode(d_opcode_o, e.op, what);
          check_size(d_size_o, e.size, what);
          check_source(d_source_o, e.source, what);
          check_error(d_error_o, e.err, what);
          check_data(d_data_o, e.data, what);
          rsp_count++;
        end
      end
    end
  end

  // Stimulus, 2 ns after each rising edge
  initial begin
    int          sent;
    logic        took;
    logic [31:0] r;
    seed        = SeedInit;
    fail_count  = 0;
    rsp_count   = 0;
    sent        = 0;
    held        = 1'b0;
    drv_illegal = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = OpGet;
    a_size_i    = 2'd2;
    a_mask_i    = 4'hf;
    a_address_i = '0;
    a_data_i    = '0;
    a_source_i  = '0;
    d_ready_i   = 1'b0;
    @(posedge rst_ni);
    @(posedge clk_i);
    #2;
    while (sent < NumTxn || a_valid_i) begin
      r = $random(seed);
      // Host ready about three cycles in four
      d_ready_i = (r[1:0] != 2'b00);
      if (!a_valid_i && sent < NumTxn && r[3:2] != 2'b00) begin
        make_request(sent);
        sent++;
      end
      @(posedge clk_i);
      took = a_valid_i && a_ready_o;
      if (took) begin
        record_accept();
      end
      #2;
      if (took) begin
        a_valid_i = 1'b0;
      end
    end
    // Drain the outstanding responses
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #2;
      r = $random(seed);
      d_ready_i = (r[1:0] != 2'b00);
    end
    d_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    #2;
    if (rerr_q.size() != 0) begin
      report_problem("SRAM read data was returned that no response used");
    end
    if (fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog sized for 20 cycles per transaction
  initial begin
    #(WatchdogNs);
    report_problem("Timeout: the test did not finish in the allowed time");
  end

endmodule

//--- tlul_sram_adapter.f
src/tlul_pkg.sv
src/sram_pkg.sv
src/req_checker.sv
src/sync_fifo.sv
src/sram_req_gen.sv
src/rsp_gen.sv
src/tlul_sram_adapter.sv
test/tb_clk_gen.sv
test/tb_sram_model.sv
test/tlul_sram_adapter_chk.sv
test/tb_tlul_sram_adapter.sv
